// File: dcache_pkg.sv
`default_nettype none
////////////////////////////////////////
// Data cache shared definitions
// Geometry, address fields, bus structs
////////////////////////////////////////
package dcache_pkg;

   // Geometry kept small so sets conflict often
   localparam int ADDR_W  = 32;
   localparam int DATA_W  = 32;
   localparam int BSEL_W  = DATA_W / 8;
   localparam int BLOCK_W = 4;
   localparam int SET_W   = 4;
   localparam int WORD_W  = 2;
   // Tag is everything above index and line offset
   localparam int TAG_W   = ADDR_W - SET_W - BLOCK_W;

   typedef logic [ADDR_W-1:0]       addr_t;
   typedef logic [DATA_W-1:0]       data_t;
   typedef logic [BSEL_W-1:0]       bsel_t;
   typedef logic [SET_W-1:0]        set_t;
   typedef logic [WORD_W-1:0]       word_t;
   // Data memory address is set and word index side by side
   typedef logic [SET_W+WORD_W-1:0] word_adr_t;
   typedef logic [TAG_W-1:0]        tag_t;

   typedef struct packed {
      logic valid;
      tag_t tag;
   } tag_entry_t;

   // CPU request held as a level until acknowledge
   typedef struct packed {
      logic  req;
      logic  we;
      addr_t adr;
      data_t dat;
      bsel_t bsel;
   } cpu_req_t;

   // One returned memory word at byte address adr
   typedef struct packed {
      logic  stb;
      addr_t adr;
      data_t dat;
   } mem_rsp_t;

   // Fill engine write into the data memory
   typedef struct packed {
      logic      we;
      word_adr_t adr;
      data_t     dat;
   } fill_wr_t;

   // Address field helpers
   function automatic set_t set_of(addr_t adr);
      return adr[BLOCK_W +: SET_W];
   endfunction

   function automatic tag_t tag_of(addr_t adr);
      return adr[ADDR_W-1 -: TAG_W];
   endfunction

   function automatic word_adr_t word_adr_of(addr_t adr);
      return adr[BLOCK_W+SET_W-1 : BLOCK_W-WORD_W];
   endfunction

   function automatic addr_t line_base(addr_t adr);
      return {adr[ADDR_W-1:BLOCK_W], {BLOCK_W{1'b0}}};
   endfunction

endpackage
`default_nettype wire

// File: dcache_dpram.sv
`timescale 1ns/1ps
`default_nettype none
////////////////////////////////////////
// Single-clock simple dual-port RAM
// Registered read with write bypass
////////////////////////////////////////
module dcache_dpram #(
   parameter int  ADDR_BITS = 4,
   parameter type payload_t = logic [31:0]
) (
   input  wire logic                 clk,
   input  wire logic [ADDR_BITS-1:0] raddr_i,
   input  wire logic [ADDR_BITS-1:0] waddr_i,
   input  wire logic                 we_i,
   input  wire payload_t             din_i,
   output payload_t                  dout_o
);

   payload_t mem [0:(2**ADDR_BITS)-1];

   // Write port
   always_ff @(posedge clk) begin
      if (we_i) begin
         mem[waddr_i] <= din_i;
      end
   end

   // Same-address write wins so the new word shows next cycle
   always_ff @(posedge clk) begin
      if (we_i && (waddr_i == raddr_i)) begin
         dout_o <= din_i;
      end else begin
         dout_o <= mem[raddr_i];
      end
   end

endmodule
`default_nettype wire

// File: dcache_fill.sv
`timescale 1ns/1ps
`default_nettype none
////////////////////////////////////////
// Data cache line-fill engine
// Requests a line, counts returned words
// and turns them into data RAM writes
////////////////////////////////////////
module dcache_fill (
   input  wire logic                 clk,
   input  wire logic                 rst,
   input  wire logic                 fill_start_i,
   input  wire dcache_pkg::addr_t    line_adr_i,
   input  wire dcache_pkg::mem_rsp_t mem_rsp_i,
   output logic                      refill_req_o,
   output dcache_pkg::addr_t         refill_adr_o,
   output dcache_pkg::fill_wr_t      fill_wr_o,
   output logic                      fill_done_o
);

   logic              busy_q;
   dcache_pkg::addr_t line_q;
   dcache_pkg::word_t cnt_q;
   logic              accept;
   logic              last;

   // Only take words of the open line while a refill runs
   assign accept = busy_q & mem_rsp_i.stb &
                   (dcache_pkg::line_base(mem_rsp_i.adr) == line_q);
   // Final word of the line
   assign last = (cnt_q == '1);

   always_ff @(posedge clk) begin
      if (rst) begin
         busy_q <= 1'b0;
         cnt_q  <= '0;
      end else if (fill_start_i) begin
         busy_q <= 1'b1;
         cnt_q  <= '0;
      end else if (accept) begin
         cnt_q <= cnt_q + 1'b1;
         // Last word closes the request so no further words count
         if (last) begin
            busy_q <= 1'b0;
         end
      end
   end

   // Line base held for the whole refill
   always_ff @(posedge clk) begin
      if (fill_start_i) begin
         line_q <= dcache_pkg::line_base(line_adr_i);
      end
   end

   assign refill_req_o = busy_q;
   assign refill_adr_o = line_q;
   assign fill_done_o  = accept & last;

   // Words arrive in order, so the counter is the word index
   always_comb begin
      fill_wr_o.we  = accept;
      fill_wr_o.adr = {dcache_pkg::set_of(line_q), cnt_q};
      fill_wr_o.dat = mem_rsp_i.dat;
   end

endmodule
`default_nettype wire

// File: dcache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
////////////////////////////////////////
// Data cache lookup controller
// FSM, tag compare, byte merge and
// write port arbitration
////////////////////////////////////////
module dcache_ctrl (
   input  wire logic                   clk,
   input  wire logic                   rst,
   // CPU side
   input  wire dcache_pkg::cpu_req_t   cpu_req_i,
   output logic                        cpu_ack_o,
   output dcache_pkg::data_t           cpu_dat_o,
   // Invalidation
   input  wire logic                   inv_i,
   input  wire dcache_pkg::addr_t      inv_adr_i,
   output logic                        inv_ack_o,
   // Tag memory
   output dcache_pkg::set_t            tag_raddr_o,
   output dcache_pkg::set_t            tag_waddr_o,
   output logic                        tag_we_o,
   output dcache_pkg::tag_entry_t      tag_din_o,
   input  wire dcache_pkg::tag_entry_t tag_dout_i,
   // Data memory
   output dcache_pkg::word_adr_t       data_raddr_o,
   output dcache_pkg::word_adr_t       data_waddr_o,
   output logic                        data_we_o,
   output dcache_pkg::data_t           data_din_o,
   input  wire dcache_pkg::data_t      data_dout_i,
   // Fill engine
   output logic                        fill_start_o,
   output dcache_pkg::addr_t           line_adr_o,
   input  wire dcache_pkg::fill_wr_t   fill_wr_i,
   input  wire logic                   fill_done_i
);

   typedef enum logic [1:0] {
      IDLE,
      LOOKUP,
      FILL,
      WRITE_DONE
   } state_t;

   state_t                 state_q;
   state_t                 state_d;
   logic                   hit;
   logic                   write_hit;
   dcache_pkg::data_t      merged;
   dcache_pkg::word_adr_t  wr_adr_q;
   dcache_pkg::data_t      wr_dat_q;

   // Both memories follow the request address every cycle
   assign tag_raddr_o  = dcache_pkg::set_of(cpu_req_i.adr);
   assign data_raddr_o = dcache_pkg::word_adr_of(cpu_req_i.adr);

   // Stored entry valid and tag equal
   assign hit = tag_dout_i.valid &
                (tag_dout_i.tag == dcache_pkg::tag_of(cpu_req_i.adr));
   assign write_hit = (state_q == LOOKUP) & cpu_req_i.req & cpu_req_i.we & hit;

   // Read data straight off the data RAM
   assign cpu_dat_o = data_dout_i;
   // Read hit, write hit or write miss all end in the lookup cycle
   assign cpu_ack_o = (state_q == LOOKUP) & cpu_req_i.req & (hit | cpu_req_i.we);
   // Invalidation served only from IDLE
   assign inv_ack_o = (state_q == IDLE) & inv_i;

   // Read miss kicks off the fill engine
   assign fill_start_o = (state_q == LOOKUP) & cpu_req_i.req & ~cpu_req_i.we & ~hit;
   assign line_adr_o   = dcache_pkg::line_base(cpu_req_i.adr);

   // Selected bytes from the CPU, the rest from the cached word
   always_comb begin
      merged = data_dout_i;
      for (int b = 0; b < dcache_pkg::BSEL_W; b++) begin
         if (cpu_req_i.bsel[b]) begin
            merged[8*b +: 8] = cpu_req_i.dat[8*b +: 8];
         end
      end
   end

   // Merged word written one cycle later in WRITE_DONE
   always_ff @(posedge clk) begin
      if (write_hit) begin
         wr_adr_q <= dcache_pkg::word_adr_of(cpu_req_i.adr);
         wr_dat_q <= merged;
      end
   end

   always_comb begin
      state_d = state_q;
      case (state_q)
         IDLE: begin
            // Invalidation wins over a new request
            if (!inv_i && cpu_req_i.req) begin
               state_d = LOOKUP;
            end
         end
         LOOKUP: begin
            if (!cpu_req_i.req) begin
               state_d = IDLE;
            end else if (write_hit) begin
               state_d = WRITE_DONE;
            end else if (cpu_req_i.we || hit) begin
               state_d = IDLE;
            end else begin
               state_d = FILL;
            end
         end
         // Look up again once the line is in
         FILL: begin
            if (fill_done_i) begin
               state_d = LOOKUP;
            end
         end
         WRITE_DONE: state_d = IDLE;
         default:    state_d = IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state_q <= IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   // Write port owner picked by state
   always_comb begin
      tag_we_o     = 1'b0;
      tag_waddr_o  = dcache_pkg::set_of(cpu_req_i.adr);
      tag_din_o    = '0;
      data_we_o    = 1'b0;
      data_waddr_o = wr_adr_q;
      data_din_o   = wr_dat_q;
      case (state_q)
         IDLE: begin
            // Clear the valid bit of the named set
            if (inv_i) begin
               tag_we_o    = 1'b1;
               tag_waddr_o = dcache_pkg::set_of(inv_adr_i);
            end
         end
         FILL: begin
            data_we_o    = fill_wr_i.we;
            data_waddr_o = fill_wr_i.adr;
            data_din_o   = fill_wr_i.dat;
            // Mark the completed line valid with the request's tag
            if (fill_done_i) begin
               tag_we_o      = 1'b1;
               tag_din_o.valid = 1'b1;
               tag_din_o.tag   = dcache_pkg::tag_of(cpu_req_i.adr);
            end
         end
         WRITE_DONE: data_we_o = 1'b1;
         default: begin
         end
      endcase
   end

endmodule
`default_nettype wire

// File: dcache_top.sv
`timescale 1ns/1ps
`default_nettype none
////////////////////////////////////////
// Direct-mapped data cache top level
// Controller, fill engine, tag and data RAM
////////////////////////////////////////
module dcache_top (
   input  wire logic                 clk,
   input  wire logic                 rst,
   input  wire dcache_pkg::cpu_req_t cpu_req_i,
   output logic                      cpu_ack_o,
   output dcache_pkg::data_t         cpu_dat_o,
   input  wire logic                 inv_i,
   input  wire dcache_pkg::addr_t    inv_adr_i,
   output logic                      inv_ack_o,
   output logic                      refill_req_o,
   output dcache_pkg::addr_t         refill_adr_o,
   input  wire dcache_pkg::mem_rsp_t mem_rsp_i
);

   // Tag RAM port
   dcache_pkg::set_t        tag_raddr;
   dcache_pkg::set_t        tag_waddr;
   logic                    tag_we;
   dcache_pkg::tag_entry_t  tag_din;
   dcache_pkg::tag_entry_t  tag_dout;
   // Data RAM port
   dcache_pkg::word_adr_t   data_raddr;
   dcache_pkg::word_adr_t   data_waddr;
   logic                    data_we;
   dcache_pkg::data_t       data_din;
   dcache_pkg::data_t       data_dout;
   // Controller to fill engine
   logic                    fill_start;
   dcache_pkg::addr_t       line_adr;
   dcache_pkg::fill_wr_t    fill_wr;
   logic                    fill_done;

   dcache_ctrl ctrl_i (
      .clk          (clk),
      .rst          (rst),
      .cpu_req_i    (cpu_req_i),
      .cpu_ack_o    (cpu_ack_o),
      .cpu_dat_o    (cpu_dat_o),
      .inv_i        (inv_i),
      .inv_adr_i    (inv_adr_i),
      .inv_ack_o    (inv_ack_o),
      .tag_raddr_o  (tag_raddr),
      .tag_waddr_o  (tag_waddr),
      .tag_we_o     (tag_we),
      .tag_din_o    (tag_din),
      .tag_dout_i   (tag_dout),
      .data_raddr_o (data_raddr),
      .data_waddr_o (data_waddr),
      .data_we_o    (data_we),
      .data_din_o   (data_din),
      .data_dout_i  (data_dout),
      .fill_start_o (fill_start),
      .line_adr_o   (line_adr),
      .fill_wr_i    (fill_wr),
      .fill_done_i  (fill_done)
   );

   dcache_fill fill_i (
      .clk          (clk),
      .rst          (rst),
      .fill_start_i (fill_start),
      .line_adr_i   (line_adr),
      .mem_rsp_i    (mem_rsp_i),
      .refill_req_o (refill_req_o),
      .refill_adr_o (refill_adr_o),
      .fill_wr_o    (fill_wr),
      .fill_done_o  (fill_done)
   );

   // One entry per set
   dcache_dpram #(
      .ADDR_BITS (dcache_pkg::SET_W),
      .payload_t (dcache_pkg::tag_entry_t)
   ) tag_ram (
      .clk     (clk),
      .raddr_i (tag_raddr),
      .waddr_i (tag_waddr),
      .we_i    (tag_we),
      .din_i   (tag_din),
      .dout_o  (tag_dout)
   );

   // One word per set and word index
   dcache_dpram #(
      .ADDR_BITS (dcache_pkg::SET_W + dcache_pkg::WORD_W),
      .payload_t (dcache_pkg::data_t)
   ) data_ram (
      .clk     (clk),
      .raddr_i (data_raddr),
      .waddr_i (data_waddr),
      .we_i    (data_we),
      .din_i   (data_din),
      .dout_o  (data_dout)
   );

endmodule
`default_nettype wire

// File: tb_dcache.sv
`timescale 1ns/1ps
`default_nettype none
////////////////////////////////////////
// Data cache testbench
// File-driven reads, writes, invalidates
// against a line memory model
////////////////////////////////////////
module tb_dcache;

   localparam int                WAIT_LIMIT = 500;
   localparam int                NUM_SETS   = 2 ** dcache_pkg::SET_W;
   // Memory words hold their byte address XOR this key
   localparam dcache_pkg::data_t MEM_KEY    = 32'h5A5A0000;

   logic                 clk;
   logic                 rst;
   dcache_pkg::cpu_req_t cpu_req;
   logic                 cpu_ack;
   dcache_pkg::data_t    cpu_dat;
   logic                 inv;
   dcache_pkg::addr_t    inv_adr;
   logic                 inv_ack;
   logic                 refill_req;
   dcache_pkg::addr_t    refill_adr;
   dcache_pkg::mem_rsp_t mem_rsp;

   // Stimulus reader state
   integer               seed;
   int                   fd;
   int                   code;
   int                   op_cnt;
   int                   s;
   logic [7:0]           op;
   logic [8*160-1:0]     skip;
   dcache_pkg::addr_t    f_adr;
   dcache_pkg::bsel_t    f_bsel;
   dcache_pkg::data_t    f_wdat;
   dcache_pkg::data_t    f_exp;
   int                   f_hit;

   dcache_top dut_i (
      .clk          (clk),
      .rst          (rst),
      .cpu_req_i    (cpu_req),
      .cpu_ack_o    (cpu_ack),
      .cpu_dat_o    (cpu_dat),
      .inv_i        (inv),
      .inv_adr_i    (inv_adr),
      .inv_ack_o    (inv_ack),
      .refill_req_o (refill_req),
      .refill_adr_o (refill_adr),
      .mem_rsp_i    (mem_rsp)
   );

   // 4 ns clock
   always #2 clk = ~clk;

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("=== FAIL ===");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_data(input string name, input dcache_pkg::data_t exp,
                             input dcache_pkg::data_t got);
      if (got !== exp) begin
         abort_run($sformatf("ERR %s expected %h got %h", name, exp, got));
      end
   endtask

   task automatic check_addr(input string name, input dcache_pkg::addr_t exp,
                             input dcache_pkg::addr_t got);
      if (got !== exp) begin
         abort_run($sformatf("ERR %s expected %h got %h", name, exp, got));
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic got);
      if (got !== exp) begin
         abort_run($sformatf("ERR %s expected %h got %h", name, exp, got));
      end
   endtask

   function automatic dcache_pkg::data_t memory_word(input dcache_pkg::addr_t adr);
      return adr ^ MEM_KEY;
   endfunction

   // Outside memory returns four words in order with random gaps
   task automatic serve_line(input dcache_pkg::addr_t base);
      int                w;
      int                gap;
      dcache_pkg::addr_t wadr;
      for (w = 0; w < 4; w++) begin
         wadr = base + dcache_pkg::addr_t'(4 * w);
         @(posedge clk);
         #0.5;
         mem_rsp.stb = 1'b1;
         mem_rsp.adr = wadr;
         mem_rsp.dat = memory_word(wadr);
         gap = (w == 3) ? 0 : ($random(seed) & 3);
         repeat (gap) begin
            @(posedge clk);
            #0.5;
            mem_rsp.stb = 1'b0;
         end
      end
      @(posedge clk);
      #0.5;
      mem_rsp.stb = 1'b0;
      // Request gone in the cycle after the final word
      if (refill_req !== 1'b0) begin
         abort_run("refill request still high after the last word of the line");
      end
   endtask

   // One CPU read or write that serves refills while waiting for the acknowledge
   task automatic cpu_access(input logic we, input dcache_pkg::addr_t adr,
                             input dcache_pkg::bsel_t bsel, input dcache_pkg::data_t wdat,
                             input dcache_pkg::data_t exp, input logic exp_hit);
      int                cyc;
      int                fill_cyc;
      logic              acked;
      logic              refilled;
      dcache_pkg::data_t got;
      cyc      = 0;
      fill_cyc = 0;
      acked    = 1'b0;
      refilled = 1'b0;
      got      = '0;
      @(posedge clk);
      #0.5;
      cpu_req.req  = 1'b1;
      cpu_req.we   = we;
      cpu_req.adr  = adr;
      cpu_req.dat  = wdat;
      cpu_req.bsel = bsel;
      while (!acked && cyc < WAIT_LIMIT) begin
         @(negedge clk);
         cyc++;
         if (cpu_ack) begin
            acked = 1'b1;
            got   = cpu_dat;
         end else if (refill_req) begin
            refilled = 1'b1;
            check_addr("refill_adr_o", adr & 32'hFFFF_FFF0, refill_adr);
            serve_line(refill_adr);
            fill_cyc = cyc;
         end
      end
      if (!acked) begin
         abort_run("no acknowledge from the cache within the wait limit");
      end
      @(posedge clk);
      #0.5;
      cpu_req = '0;
      check_flag("hit", exp_hit, !refilled);
      // Hits and all writes end on the second cycle
      if (!refilled && cyc != 2) begin
         abort_run($sformatf("acknowledge came after %0d cycles instead of 2", cyc));
      end
      // A miss ends with one lookup cycle after its refill
      if (refilled && cyc != fill_cyc + 1) begin
         abort_run("read miss not acknowledged in the cycle after its refill");
      end
      if (!we) begin
         check_data("cpu_dat_o", exp, got);
      end
   endtask

   task automatic invalidate(input dcache_pkg::addr_t adr);
      int   cyc;
      logic acked;
      cyc   = 0;
      acked = 1'b0;
      @(posedge clk);
      #0.5;
      inv     = 1'b1;
      inv_adr = adr;
      while (!acked && cyc < WAIT_LIMIT) begin
         @(negedge clk);
         cyc++;
         acked = inv_ack;
      end
      if (!acked) begin
         abort_run("no invalidation acknowledge within the wait limit");
      end
      // Seen in IDLE, so acknowledged in the same cycle
      if (cyc != 1) begin
         abort_run($sformatf("invalidation acknowledged after %0d cycles instead of 1", cyc));
      end
      @(posedge clk);
      #0.5;
      inv = 1'b0;
      @(negedge clk);
      check_flag("inv_ack_o", 1'b0, inv_ack);
   endtask

   initial begin
      seed    = 32'h82df1919;
      op_cnt  = 0;
      clk     = 1'b0;
      rst     = 1'b1;
      cpu_req = '0;
      inv     = 1'b0;
      inv_adr = '0;
      mem_rsp = '0;
      repeat (3) @(posedge clk);
      #0.5;
      rst = 1'b0;
      @(negedge clk);
      check_flag("cpu_ack_o", 1'b0, cpu_ack);
      check_flag("refill_req_o", 1'b0, refill_req);
      check_flag("inv_ack_o", 1'b0, inv_ack);
      // Clear every set so the cache starts empty
      for (s = 0; s < NUM_SETS; s++) begin
         invalidate(dcache_pkg::addr_t'(s) << dcache_pkg::BLOCK_W);
      end
      fd = $fopen("dcache_stimulus.txt", "r");
      if (fd == 0) begin
         abort_run("cannot open dcache_stimulus.txt");
      end
      code = $fscanf(fd, " %c", op);
      while (code == 1) begin
         if (op == "#") begin
            code = $fgets(skip, fd);
         end else begin
            code = $fscanf(fd, " %h %h %h %h %d", f_adr, f_bsel, f_wdat, f_exp, f_hit);
            if (code != 5) begin
               abort_run("malformed line in the stimulus file");
            end
            case (op)
               "R": cpu_access(1'b0, f_adr, f_bsel, f_wdat, f_exp, f_hit != 0);
               "W": cpu_access(1'b1, f_adr, f_bsel, f_wdat, f_exp, f_hit != 0);
               "I": invalidate(f_adr);
               default: abort_run("unknown operation in the stimulus file");
            endcase
            op_cnt++;
         end
         code = $fscanf(fd, " %c", op);
      end
      $fclose(fd);
      if (op_cnt > 0) begin
         $display("=== PASS ===");
         $finish;
      end else begin
         abort_run("stimulus file held no operations");
      end
   end

endmodule
`default_nettype wire

// File: dcache_stimulus.txt
# op address bsel wdata expected hit
# R read W write I invalidate, hex fields, hit 1 means no refill allowed
R 00001004 0 00000000 5A5A1004 0
R 0000100C 0 00000000 5A5A100C 1
R 00001000 0 00000000 5A5A1000 1
W 00001008 3 1122AABB 00000000 1
R 00001008 0 00000000 5A5AAABB 1
W 00001004 A DEADBEEF 00000000 1
R 00001004 0 00000000 DE5ABE04 1
W 0000100C F CAFEF00D 00000000 1
R 0000100C 0 00000000 CAFEF00D 1
W 00002040 F 12345678 00000000 1
R 00002040 0 00000000 5A5A2040 0
R 00002044 0 00000000 5A5A2044 1
R 00003050 0 00000000 5A5A3050 0
R 00004050 0 00000000 5A5A4050 0
R 00003054 0 00000000 5A5A3054 0
R 00004058 0 00000000 5A5A4058 0
R 0000405C 0 00000000 5A5A405C 1
R 00005000 0 00000000 5A5A5000 0
R 00001008 0 00000000 5A5A1008 0
I 00002040 0 00000000 00000000 0
R 00002048 0 00000000 5A5A2048 0
R 0000204C 0 00000000 5A5A204C 1
I 00007070 0 00000000 00000000 0
R 00007070 0 00000000 5A5A7070 0
I 0000100C 0 00000000 00000000 0
W 00001004 F 0BADF00D 00000000 1
R 00001004 0 00000000 5A5A1004 0
R 00001000 0 00000000 5A5A1000 1

// File: verilog.f
dcache_pkg.sv
dcache_dpram.sv
dcache_fill.sv
dcache_ctrl.sv
dcache_top.sv
tb_dcache.sv

// File: Makefile
# Verilator build and run of the data cache testbench
VERILATOR ?= verilator
TOP       ?= tb_dcache
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "Test failed"; exit 1; fi
	@grep -q "=== PASS ===" $(LOG) || (echo "Test did not finish"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
